// ==== aluPkg.sv ====
package aluPkg;

   localparam int dataWidth = 32;
   localparam int addrWidth = 8;

   // command codes as decoded by the ALU
   typedef enum logic [2:0] {
      cmdAdd  = 3'd0,
      cmdSub  = 3'd1,
      cmdXor  = 3'd2,
      cmdSlt  = 3'd3,
      cmdAnd  = 3'd4,
      cmdNand = 3'd5,
      cmdNor  = 3'd6,
      cmdOr   = 3'd7
   } aluCmd_e;

   // byte offsets of the APB register map
   typedef enum logic [addrWidth-1:0] {
      addrOpA    = 8'h00,
      addrOpB    = 8'h04,
      addrCmd    = 8'h08,
      addrResult = 8'h0C,
      addrFlags  = 8'h10
   } regAddr_e;

   // declared MSB first so that the packed value puts zero in bit 0
   typedef struct packed {
      logic overflow;
      logic carryout;
      logic zero;
   } aluFlags_t;

   typedef struct packed {
      logic [dataWidth-1:0] operandA;
      logic [dataWidth-1:0] operandB;
      aluCmd_e              command;
   } aluReq_t;

   typedef struct packed {
      logic                 psel;
      logic                 penable;
      logic                 pwrite;
      logic [addrWidth-1:0] paddr;
      logic [dataWidth-1:0] pwdata;
   } apbReq_t;

   typedef struct packed {
      logic [dataWidth-1:0] prdata;
      logic                 pready;
      logic                 pslverr;
   } apbRsp_t;

endpackage

// ==== aluAdder.sv ====
module aluAdder (
   input  logic [aluPkg::dataWidth-1:0] a,
   input  logic [aluPkg::dataWidth-1:0] b,
   input  logic                         carryIn,
   input  logic                         invertB,
   output logic [aluPkg::dataWidth-1:0] sum,
   output logic                         carryout,
   output logic                         overflow
);

   logic [aluPkg::dataWidth-1:0] bEff;
   logic [aluPkg::dataWidth:0]   carry;

   // subtract is a plus the one's complement of b plus the carry-in
   assign bEff     = invertB ? ~b : b;
   assign carry[0] = carryIn;

   for (genvar i = 0; i < aluPkg::dataWidth; i++) begin : gBit
      logic halfSum;

      assign halfSum    = a[i] ^ bEff[i];
      assign sum[i]     = halfSum ^ carry[i];
      assign carry[i+1] = (a[i] & bEff[i]) | (halfSum & carry[i]);
   end

   assign carryout = carry[aluPkg::dataWidth];

   // signed overflow shows up as a mismatch between the carries into and out of the MSB
   assign overflow = carry[aluPkg::dataWidth-1] ^ carry[aluPkg::dataWidth];

endmodule

// ==== alu.sv ====
module alu (
   input  aluPkg::aluReq_t               req,
   output logic [aluPkg::dataWidth-1:0]  result,
   output aluPkg::aluFlags_t             flags
);

   logic [aluPkg::dataWidth-1:0] adderSum;
   logic                         adderCarry;
   logic                         adderOverflow;
   logic                         useSub;
   logic                         lessThan;

   // subtract and set-less-than both need a minus b
   assign useSub = (req.command == aluPkg::cmdSub) || (req.command == aluPkg::cmdSlt);

   aluAdder adder_i (
      .a        (req.operandA),
      .b        (req.operandB),
      .carryIn  (useSub),
      .invertB  (useSub),
      .sum      (adderSum),
      .carryout (adderCarry),
      .overflow (adderOverflow)
   );

   // the sign of a minus b is only trustworthy when the subtraction did not overflow
   assign lessThan = adderSum[aluPkg::dataWidth-1] ^ adderOverflow;

   always_comb begin
      result         = adderSum;
      flags.carryout = 1'b0;
      flags.overflow = 1'b0;
      case (req.command)
         aluPkg::cmdAdd,
         aluPkg::cmdSub: begin
            result         = adderSum;
            flags.carryout = adderCarry;
            flags.overflow = adderOverflow;
         end
         aluPkg::cmdXor: begin
            result = req.operandA ^ req.operandB;
         end
         aluPkg::cmdSlt: begin
            result = {aluPkg::dataWidth{lessThan}};
         end
         aluPkg::cmdAnd: begin
            result = req.operandA & req.operandB;
         end
         aluPkg::cmdNand: begin
            result = ~(req.operandA & req.operandB);
         end
         aluPkg::cmdNor: begin
            result = ~(req.operandA | req.operandB);
         end
         aluPkg::cmdOr: begin
            result = req.operandA | req.operandB;
         end
         default: begin
            result = adderSum;
         end
      endcase
   end

   assign flags.zero = (result == '0);

   // logic and compare commands never report arithmetic status from the adder
   always_comb begin
      if ((req.command != aluPkg::cmdAdd) && (req.command != aluPkg::cmdSub)) begin
         assert final (!flags.carryout && !flags.overflow)
            else $error("alu: carry or overflow set for a non-arithmetic command");
      end
   end

endmodule

// ==== aluApbRegs.sv ====
module aluApbRegs (
   input  logic                         clk,
   input  logic                         rstN,
   input  aluPkg::apbReq_t              apbReq,
   output aluPkg::apbRsp_t              apbRsp,
   output aluPkg::aluReq_t              aluReq,
   input  logic [aluPkg::dataWidth-1:0] aluResult,
   input  aluPkg::aluFlags_t            aluFlags
);

   logic [aluPkg::dataWidth-1:0] opAReg;
   logic [aluPkg::dataWidth-1:0] opBReg;
   aluPkg::aluCmd_e              cmdReg;
   logic [aluPkg::dataWidth-1:0] resultReg;
   aluPkg::aluFlags_t            flagsReg;

   aluPkg::regAddr_e             regAddr;
   aluPkg::aluCmd_e              wrCmd;
   logic                         setupPhase;
   logic                         accessPhase;
   logic                         addrValid;
   logic                         addrReadOnly;
   logic                         wrAllowed;
   logic                         cmdWrite;
   logic [aluPkg::dataWidth-1:0] rdMux;

   assign setupPhase  = apbReq.psel && !apbReq.penable;
   assign accessPhase = apbReq.psel && apbReq.penable;

   assign regAddr = aluPkg::regAddr_e'(apbReq.paddr);
   assign wrCmd   = aluPkg::aluCmd_e'(apbReq.pwdata[2:0]);

   always_comb begin
      rdMux        = '0;
      addrValid    = 1'b1;
      addrReadOnly = 1'b0;
      case (regAddr)
         aluPkg::addrOpA: begin
            rdMux = opAReg;
         end
         aluPkg::addrOpB: begin
            rdMux = opBReg;
         end
         aluPkg::addrCmd: begin
            rdMux = {{(aluPkg::dataWidth-3){1'b0}}, cmdReg};
         end
         aluPkg::addrResult: begin
            rdMux        = resultReg;
            addrReadOnly = 1'b1;
         end
         aluPkg::addrFlags: begin
            rdMux        = {{(aluPkg::dataWidth-3){1'b0}}, flagsReg};
            addrReadOnly = 1'b1;
         end
         default: begin
            addrValid = 1'b0;
         end
      endcase
   end

   assign wrAllowed = accessPhase && apbReq.pwrite && addrValid && !addrReadOnly;
   assign cmdWrite  = wrAllowed && (regAddr == aluPkg::addrCmd);

   // during a command write the ALU already sees the new command, so its
   // outputs can be captured at the same edge that stores the command
   assign aluReq.operandA = opAReg;
   assign aluReq.operandB = opBReg;
   assign aluReq.command  = cmdWrite ? wrCmd : cmdReg;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         opAReg    <= '0;
         opBReg    <= '0;
         cmdReg    <= aluPkg::cmdAdd;
         resultReg <= '0;
         flagsReg  <= '0;
      end else if (wrAllowed) begin
         case (regAddr)
            aluPkg::addrOpA: begin
               opAReg <= apbReq.pwdata;
            end
            aluPkg::addrOpB: begin
               opBReg <= apbReq.pwdata;
            end
            aluPkg::addrCmd: begin
               cmdReg    <= wrCmd;
               resultReg <= aluResult;
               flagsReg  <= aluFlags;
            end
            default: begin
               cmdReg <= cmdReg;
            end
         endcase
      end
   end

   // no wait states, so every transfer finishes in its first access cycle
   assign apbRsp.pready  = 1'b1;
   assign apbRsp.prdata  = (accessPhase && !apbReq.pwrite) ? rdMux : '0;
   assign apbRsp.pslverr = accessPhase && (!addrValid || (apbReq.pwrite && addrReadOnly));

   // an access cycle must follow its setup cycle directly
   assert property (@(posedge clk) disable iff (!rstN)
      apbReq.penable |-> $past(setupPhase))
      else $error("aluApbRegs: penable without a preceding setup cycle");

   assert property (@(posedge clk) disable iff (!rstN)
      apbRsp.pslverr |-> accessPhase)
      else $error("aluApbRegs: pslverr outside an access cycle");

endmodule

// ==== aluApbTop.sv ====
module aluApbTop (
   input  logic            clk,
   input  logic            rstN,
   input  aluPkg::apbReq_t apbReq,
   output aluPkg::apbRsp_t apbRsp
);

   aluPkg::aluReq_t              aluReq;
   logic [aluPkg::dataWidth-1:0] aluResult;
   aluPkg::aluFlags_t            aluFlags;

   aluApbRegs regs_i (
      .clk       (clk),
      .rstN      (rstN),
      .apbReq    (apbReq),
      .apbRsp    (apbRsp),
      .aluReq    (aluReq),
      .aluResult (aluResult),
      .aluFlags  (aluFlags)
   );

   // the ALU is purely combinational and the register file captures its results
   alu alu_i (
      .req    (aluReq),
      .result (aluResult),
      .flags  (aluFlags)
   );

endmodule

// ==== aluApbTb.sv ====
module aluApbTb;

   localparam int clkPeriod    = 40;
   localparam int driveDelay   = 2;
   localparam int sampleDelay  = 10;
   localparam int resetCycles  = 16;
   localparam int cyclesPerRow = 10;
   localparam int randomRows   = 48;
   localparam int marginCycles = 200;

   // one operation of the stimulus table with its expected outcome
   typedef struct packed {
      logic [31:0]       a;
      logic [31:0]       b;
      aluPkg::aluCmd_e   cmd;
      logic [31:0]       result;
      aluPkg::aluFlags_t flags;
   } opRow_t;

   logic            clk;
   logic            rstN;
   aluPkg::apbReq_t apbReq;
   aluPkg::apbRsp_t apbRsp;

   opRow_t      rows[$];
   logic [31:0] rngState;
   logic        tableReady;

   aluApbTop dut_i (
      .clk    (clk),
      .rstN   (rstN),
      .apbReq (apbReq),
      .apbRsp (apbRsp)
   );

   initial clk = 1'b0;
   always #(clkPeriod / 2) clk = ~clk;

   task automatic stopWithFailure(input string line);
      $display("%s", line);
      $display("Regression failed");
      $fatal(1, "stopping at the first error");
   endtask

   function automatic logic [31:0] nextRandom();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   // expected behavior of each ALU command and its flags
   function automatic opRow_t modelRow(input logic [31:0] a, input logic [31:0] b,
                                       input aluPkg::aluCmd_e cmd);
      opRow_t      row;
      logic [32:0] wide;
      row.a     = a;
      row.b     = b;
      row.cmd   = cmd;
      row.flags = '0;
      case (cmd)
         aluPkg::cmdAdd: begin
            wide               = {1'b0, a} + {1'b0, b};
            row.result         = wide[31:0];
            row.flags.carryout = wide[32];
            row.flags.overflow = (a[31] == b[31]) && (wide[31] != a[31]);
         end
         aluPkg::cmdSub: begin
            row.result         = a - b;
            // carry out means no borrow was needed
            row.flags.carryout = (a >= b);
            row.flags.overflow = (a[31] != b[31]) && (row.result[31] != a[31]);
         end
         aluPkg::cmdSlt: begin
            row.result = ($signed(a) < $signed(b)) ? {32{1'b1}} : 32'd0;
         end
         aluPkg::cmdXor: row.result = a ^ b;
         aluPkg::cmdAnd: row.result = a & b;
         aluPkg::cmdNand: row.result = ~(a & b);
         aluPkg::cmdNor: row.result = ~(a | b);
         default: row.result = a | b;
      endcase
      row.flags.zero = (row.result == 32'd0);
      return row;
   endfunction

   // flags are given as {overflow, carryout, zero}
   function automatic opRow_t makeRow(input logic [31:0] a, input logic [31:0] b,
                                      input aluPkg::aluCmd_e cmd, input logic [31:0] result,
                                      input logic [2:0] flags);
      opRow_t row;
      row.a      = a;
      row.b      = b;
      row.cmd    = cmd;
      row.result = result;
      row.flags  = aluPkg::aluFlags_t'(flags);
      return row;
   endfunction

   task automatic buildTable();
      logic [31:0]     a;
      logic [31:0]     b;
      logic [31:0]     pick;
      aluPkg::aluCmd_e cmd;
      rows.push_back(makeRow(32'h7FFFFFFF, 32'h00000001, aluPkg::cmdAdd, 32'h80000000, 3'b100));
      rows.push_back(makeRow(32'hFFFFFFFF, 32'h00000001, aluPkg::cmdAdd, 32'h00000000, 3'b011));
      rows.push_back(makeRow(32'h12345678, 32'h11111111, aluPkg::cmdAdd, 32'h23456789, 3'b000));
      rows.push_back(makeRow(32'h00000000, 32'h00000001, aluPkg::cmdSub, 32'hFFFFFFFF, 3'b000));
      rows.push_back(makeRow(32'h80000000, 32'h00000001, aluPkg::cmdSub, 32'h7FFFFFFF, 3'b110));
      rows.push_back(makeRow(32'h00000005, 32'h00000005, aluPkg::cmdSub, 32'h00000000, 3'b011));
      rows.push_back(makeRow(32'h00000010, 32'h00000003, aluPkg::cmdSub, 32'h0000000D, 3'b010));
      rows.push_back(makeRow(32'hFFFFFFFF, 32'h00000001, aluPkg::cmdSlt, 32'hFFFFFFFF, 3'b000));
      rows.push_back(makeRow(32'h00000001, 32'hFFFFFFFF, aluPkg::cmdSlt, 32'h00000000, 3'b001));
      rows.push_back(makeRow(32'h00000007, 32'h00000007, aluPkg::cmdSlt, 32'h00000000, 3'b001));
      rows.push_back(makeRow(32'h80000000, 32'h7FFFFFFF, aluPkg::cmdSlt, 32'hFFFFFFFF, 3'b000));
      rows.push_back(makeRow(32'h00000003, 32'h00000009, aluPkg::cmdSlt, 32'hFFFFFFFF, 3'b000));
      rows.push_back(makeRow(32'hA5A5A5A5, 32'hA5A5A5A5, aluPkg::cmdXor, 32'h00000000, 3'b001));
      rows.push_back(makeRow(32'hF0F0F0F0, 32'h0FF00FF0, aluPkg::cmdXor, 32'hFF00FF00, 3'b000));
      rows.push_back(makeRow(32'hF0F0F0F0, 32'h0FF00FF0, aluPkg::cmdAnd, 32'h00F000F0, 3'b000));
      rows.push_back(makeRow(32'h0F0F0F0F, 32'hF0F0F0F0, aluPkg::cmdAnd, 32'h00000000, 3'b001));
      rows.push_back(makeRow(32'hFFFFFFFF, 32'hFFFFFFFF, aluPkg::cmdNand, 32'h00000000, 3'b001));
      rows.push_back(makeRow(32'h0000FFFF, 32'h00FF00FF, aluPkg::cmdNand, 32'hFFFFFF00, 3'b000));
      rows.push_back(makeRow(32'h00000000, 32'h00000000, aluPkg::cmdNor, 32'hFFFFFFFF, 3'b000));
      rows.push_back(makeRow(32'h12340000, 32'h00005678, aluPkg::cmdNor, 32'hEDCBA987, 3'b000));
      rows.push_back(makeRow(32'h12340000, 32'h00005678, aluPkg::cmdOr, 32'h12345678, 3'b000));
      rows.push_back(makeRow(32'h00000000, 32'h00000000, aluPkg::cmdOr, 32'h00000000, 3'b001));
      for (int i = 0; i < randomRows; i++) begin
         a    = nextRandom();
         b    = nextRandom();
         pick = nextRandom();
         // an occasional equal pair hits the zero flag and the equal compare
         if (pick[7:5] == 3'd0) begin
            b = a;
         end
         cmd = aluPkg::aluCmd_e'(i[2:0]);
         rows.push_back(modelRow(a, b, cmd));
      end
   endtask

   task automatic checkResponse(input logic [7:0] addr, input logic expErr);
      assert (apbRsp.pready === 1'b1)
         else stopWithFailure($sformatf("ERROR at %0t: pready low for address 0x%02h",
                                        $time, addr));
      assert (apbRsp.pslverr === expErr)
         else stopWithFailure($sformatf(
            "ERROR at %0t: pslverr %0b for address 0x%02h, expected %0b",
            $time, apbRsp.pslverr, addr, expErr));
   endtask

   // a setup cycle and then an access cycle, starting just after a rising edge
   task automatic apbTransfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, input logic expErr,
                              output logic [31:0] rdata);
      apbReq.psel    = 1'b1;
      apbReq.penable = 1'b0;
      apbReq.pwrite  = write;
      apbReq.paddr   = addr;
      apbReq.pwdata  = wdata;
      @(posedge clk);
      #driveDelay;
      apbReq.penable = 1'b1;
      #sampleDelay;
      checkResponse(addr, expErr);
      rdata = apbRsp.prdata;
      @(posedge clk);
      #driveDelay;
      apbReq = '0;
   endtask

   task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic expErr);
      logic [31:0] unused;
      apbTransfer(1'b1, addr, data, expErr, unused);
   endtask

   task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, input logic expErr);
      apbTransfer(1'b0, addr, 32'd0, expErr, data);
   endtask

   task automatic expectEqual(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      assert (got === expected)
         else stopWithFailure($sformatf("ERROR at %0t: %s read 0x%08h, expected 0x%08h",
                                        $time, what, got, expected));
   endtask

   task automatic readExpect(input logic [7:0] addr, input logic [31:0] expected,
                             input string what);
      logic [31:0] data;
      apbRead(addr, data, 1'b0);
      expectEqual(what, data, expected);
   endtask

   task automatic checkResetValues();
      readExpect(aluPkg::addrOpA, 32'd0, "opA after reset");
      readExpect(aluPkg::addrOpB, 32'd0, "opB after reset");
      readExpect(aluPkg::addrCmd, 32'd0, "cmd after reset");
      readExpect(aluPkg::addrResult, 32'd0, "result after reset");
      readExpect(aluPkg::addrFlags, 32'd0, "flags after reset");
   endtask

   task automatic checkRegisterAccess();
      logic [31:0] data;
      apbWrite(aluPkg::addrOpA, 32'h13579BDF, 1'b0);
      apbWrite(aluPkg::addrOpB, 32'h2468ACE0, 1'b0);
      readExpect(aluPkg::addrOpA, 32'h13579BDF, "opA readback");
      readExpect(aluPkg::addrOpB, 32'h2468ACE0, "opB readback");
      apbWrite(aluPkg::addrCmd, 32'd7, 1'b0);
      readExpect(aluPkg::addrResult, 32'h377FBFFF, "result of or");
      // writes to read-only and unmapped offsets are rejected
      apbWrite(aluPkg::addrResult, 32'hFFFFFFFF, 1'b1);
      apbWrite(aluPkg::addrFlags, 32'h00000007, 1'b1);
      apbWrite(8'h14, 32'h55555555, 1'b1);
      apbWrite(8'hFC, 32'hAAAAAAAA, 1'b1);
      apbRead(8'h14, data, 1'b1);
      apbRead(8'h03, data, 1'b1);
      readExpect(aluPkg::addrOpA, 32'h13579BDF, "opA after rejected writes");
      readExpect(aluPkg::addrOpB, 32'h2468ACE0, "opB after rejected writes");
      readExpect(aluPkg::addrCmd, 32'd7, "cmd after rejected writes");
      readExpect(aluPkg::addrResult, 32'h377FBFFF, "result after rejected writes");
      readExpect(aluPkg::addrFlags, 32'd0, "flags after rejected writes");
   endtask

   task automatic runRow(input opRow_t row, input int index);
      logic [31:0]     data;
      aluPkg::aluCmd_e cmd;
      cmd = row.cmd;
      apbWrite(aluPkg::addrOpA, row.a, 1'b0);
      apbWrite(aluPkg::addrOpB, row.b, 1'b0);
      apbWrite(aluPkg::addrCmd, {29'd0, row.cmd}, 1'b0);
      apbRead(aluPkg::addrResult, data, 1'b0);
      expectEqual($sformatf("row %0d %s result", index, cmd.name()), data, row.result);
      apbRead(aluPkg::addrFlags, data, 1'b0);
      expectEqual($sformatf("row %0d %s flags", index, cmd.name()), data, {29'd0, row.flags});
   endtask

   initial begin : mainSeq
      rstN       = 1'b0;
      apbReq     = '0;
      tableReady = 1'b0;
      rngState   = 32'd29;
      buildTable();
      tableReady = 1'b1;
      repeat (resetCycles) @(posedge clk);
      #driveDelay;
      rstN = 1'b1;
      checkResetValues();
      checkRegisterAccess();
      foreach (rows[i]) begin
         runRow(rows[i], i);
      end
      $display("applied %0d table rows", rows.size());
      $display("Regression passed");
      $finish;
   end

   initial begin : watchdog
      int limitCycles;
      wait (tableReady === 1'b1);
      limitCycles = resetCycles + rows.size() * cyclesPerRow + marginCycles;
      repeat (limitCycles) @(posedge clk);
      stopWithFailure($sformatf("Timeout: the run did not finish within %0d clock cycles",
                                limitCycles));
   end

endmodule

// ==== aluApbTop.f ====
aluPkg.sv
aluAdder.sv
alu.sv
aluApbRegs.sv
aluApbTop.sv
aluApbTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module aluApbTb -f aluApbTop.f -o aluApbSim \
   && ./obj_dir/aluApbSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
